// ==== Makefile ====
TOP := tb_soc_platform

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

obj_dir/V$(TOP): src.f $(wildcard source/*.sv testbench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ns -f src.f --top-module $(TOP)

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf obj_dir

// ==== source/bus_decoder.sv ====
`timescale 1ns/1ns

module bus_decoder (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            mem_en_i,
    input  logic [platform_pkg::ADDR_W-1:0] mem_addr_i,
    output logic                            ram_en_o,
    output logic                            rtc_en_o,
    output logic                            plic_en_o,
    output logic                            periph_en_o,
    input  logic [platform_pkg::DATA_W-1:0] ram_rdata_i,
    input  logic [platform_pkg::DATA_W-1:0] rtc_rdata_i,
    input  logic [platform_pkg::DATA_W-1:0] plic_rdata_i,
    input  logic [platform_pkg::DATA_W-1:0] periph_rdata_i,
    output logic [platform_pkg::DATA_W-1:0] mem_rdata_o
);

    platform_pkg::region_e region;
    platform_pkg::region_e region_q;    // region of the last transfer

    ////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////

    always_comb begin
        case (mem_addr_i[platform_pkg::ADDR_W-1 -: 4])
            4'h0, 4'h1:                   region = platform_pkg::REGION_RAM;
            4'h2:                         region = platform_pkg::REGION_RTC;
            4'h3, 4'h4, 4'h5, 4'h6, 4'h7: region = platform_pkg::REGION_PLIC;
            default:                      region = platform_pkg::REGION_PERIPH;
        endcase
    end

    assign ram_en_o    = mem_en_i && (region == platform_pkg::REGION_RAM);
    assign rtc_en_o    = mem_en_i && (region == platform_pkg::REGION_RTC);
    assign plic_en_o   = mem_en_i && (region == platform_pkg::REGION_PLIC);
    assign periph_en_o = mem_en_i && (region == platform_pkg::REGION_PERIPH);

    ////////////////////////////////////////////////////
    // read return
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            region_q <= platform_pkg::REGION_RAM;
        end else if (mem_en_i) begin
            region_q <= region;     // steers the mux during the next cycle
        end
    end

    always_comb begin
        case (region_q)
            platform_pkg::REGION_RTC:  mem_rdata_o = rtc_rdata_i;
            platform_pkg::REGION_PLIC: mem_rdata_o = plic_rdata_i;
            platform_pkg::REGION_PERIPH: mem_rdata_o = periph_rdata_i;
            default:                   mem_rdata_o = ram_rdata_i;
        endcase
    end

    // slaves share we/addr/wdata, so two enables would corrupt both
    a_one_enable: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({ram_en_o, rtc_en_o, plic_en_o, periph_en_o}));

endmodule

// ==== source/data_ram.sv ====
`timescale 1ns/1ns

module data_ram #(
    parameter int RAM_WORDS = 256
) (
    input  logic                            clk,
    input  logic                            en_i,
    input  logic [3:0]                      we_i,
    input  logic [$clog2(RAM_WORDS)-1:0]    addr_i,
    input  logic [platform_pkg::DATA_W-1:0] wdata_i,
    output logic [platform_pkg::DATA_W-1:0] rdata_o
);

    logic [platform_pkg::DATA_W-1:0] mem [RAM_WORDS];
    logic [platform_pkg::DATA_W-1:0] rdata_q;

    ////////////////////////////////////////////////////
    // byte writes
    ////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (we_i[b]) begin
                    mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // read word, old contents on a same-cycle write
    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_q <= mem[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== source/gpio_irq.sv ====
`timescale 1ns/1ns

module gpio_irq #(
    parameter int IRQ_COUNT = 2
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            en_i,
    input  logic [3:0]                      we_i,
    input  logic [3:0]                      addr_i,
    input  logic [platform_pkg::DATA_W-1:0] wdata_i,
    output logic [platform_pkg::DATA_W-1:0] rdata_o,
    input  logic [IRQ_COUNT-1:0]            btn_i,
    output logic [7:0]                      gpio_o,
    output logic [IRQ_COUNT-1:0]            irq_req_o,
    input  logic [IRQ_COUNT-1:0]            irq_ack_i
);

    platform_pkg::hs_state_e         state_q [IRQ_COUNT];
    logic [IRQ_COUNT-1:0]            sync1_q, sync2_q, last_q;
    logic [IRQ_COUNT-1:0]            rise;
    logic [7:0]                      gpio_q;
    logic [platform_pkg::DATA_W-1:0] rd_word;
    logic [platform_pkg::DATA_W-1:0] rdata_q;

    assign rise = sync2_q & ~last_q;

    ////////////////////////////////////////////////////
    // synchronizer, output reg, request side
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            last_q  <= '0;
            gpio_q  <= '0;
            for (int i = 0; i < IRQ_COUNT; i++) state_q[i] <= platform_pkg::HS_IDLE;
        end else begin
            sync1_q <= btn_i;
            sync2_q <= sync1_q;
            last_q  <= sync2_q;
            if (en_i && we_i[0] && addr_i == platform_pkg::GPIO_OUT) gpio_q <= wdata_i[7:0];
            for (int i = 0; i < IRQ_COUNT; i++) begin
                case (state_q[i])
                    platform_pkg::HS_IDLE:
                        if (rise[i]) state_q[i] <= platform_pkg::HS_REQ;
                    platform_pkg::HS_REQ:   // hold req until acked
                        if (irq_ack_i[i]) state_q[i] <= platform_pkg::HS_WAIT_LOW;
                    platform_pkg::HS_WAIT_LOW:
                        if (!irq_ack_i[i]) state_q[i] <= platform_pkg::HS_IDLE;
                    default: state_q[i] <= platform_pkg::HS_IDLE;
                endcase
            end
        end
    end

    always_comb begin
        for (int i = 0; i < IRQ_COUNT; i++) irq_req_o[i] = (state_q[i] == platform_pkg::HS_REQ);
    end

    always_comb begin
        rd_word = '0;
        case (addr_i)
            platform_pkg::GPIO_IN:  rd_word[IRQ_COUNT-1:0] = sync2_q;
            platform_pkg::GPIO_OUT: rd_word[7:0]           = gpio_q;
            default:                rd_word                = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (en_i) rdata_q <= rd_word;
    end

    assign rdata_o = rdata_q;
    assign gpio_o  = gpio_q;

endmodule

// ==== source/platform_pkg.sv ====
package platform_pkg;

    ////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;

    // slave selected by the top address nibble
    typedef enum logic [1:0] {
        REGION_RAM    = 2'd0,   // 0x0 - 0x1
        REGION_RTC    = 2'd1,   // 0x2
        REGION_PLIC   = 2'd2,   // 0x3 - 0x7
        REGION_PERIPH = 2'd3    // 0x8 - 0xF
    } region_e;

    // four-phase req/ack between irq sources and the plic
    typedef enum logic [1:0] {
        HS_IDLE     = 2'd0,
        HS_REQ      = 2'd1,
        HS_ACK      = 2'd2,
        HS_WAIT_LOW = 2'd3
    } hs_state_e;

    ////////////////////////////////////////////////////
    // register offsets inside each region
    ////////////////////////////////////////////////////

    localparam logic [3:0] RTC_MTIME_LO = 4'h0;
    localparam logic [3:0] RTC_MTIME_HI = 4'h4;
    localparam logic [3:0] RTC_CMP_LO   = 4'h8;
    localparam logic [3:0] RTC_CMP_HI   = 4'hC;

    localparam logic [3:0] PLIC_ENABLE  = 4'h0;
    localparam logic [3:0] PLIC_PENDING = 4'h4;
    localparam logic [3:0] PLIC_CLAIM   = 4'h8;   // read claims

    localparam logic [3:0] GPIO_IN      = 4'h0;
    localparam logic [3:0] GPIO_OUT     = 4'h4;

endpackage

// ==== source/plic.sv ====
`timescale 1ns/1ns

module plic #(
    parameter int IRQ_COUNT = 2
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            en_i,
    input  logic [3:0]                      we_i,
    input  logic [3:0]                      addr_i,
    input  logic [platform_pkg::DATA_W-1:0] wdata_i,
    output logic [platform_pkg::DATA_W-1:0] rdata_o,
    input  logic [IRQ_COUNT-1:0]            irq_req_i,
    output logic [IRQ_COUNT-1:0]            irq_ack_o,
    output logic                            mei_o
);

    // source ids are 1-based, register bit n belongs to source n
    platform_pkg::hs_state_e         state_q [IRQ_COUNT:1];
    logic [IRQ_COUNT:1]              enable_q;
    logic [IRQ_COUNT:1]              pending;
    logic [IRQ_COUNT:1]              active;
    logic [4:0]                      claim_id;
    logic                            claim_rd;
    logic                            mei_q;
    logic [platform_pkg::DATA_W-1:0] rd_word;
    logic [platform_pkg::DATA_W-1:0] rdata_q;

    assign claim_rd = en_i && !(|we_i) && (addr_i == platform_pkg::PLIC_CLAIM);

    always_comb begin
        for (int i = 1; i <= IRQ_COUNT; i++) begin
            pending[i]     = (state_q[i] == platform_pkg::HS_REQ);
            irq_ack_o[i-1] = (state_q[i] == platform_pkg::HS_ACK);
        end
    end

    assign active = pending & enable_q;

    // lowest active id wins
    always_comb begin
        claim_id = '0;
        for (int i = IRQ_COUNT; i >= 1; i--) begin
            if (active[i]) claim_id = 5'(i);
        end
    end

    ////////////////////////////////////////////////////
    // enable register and ack side of the handshake
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q <= '0;
            mei_q    <= 1'b0;
            for (int i = 1; i <= IRQ_COUNT; i++) begin
                state_q[i] <= platform_pkg::HS_IDLE;
            end
        end else begin
            if (en_i && (|we_i) && addr_i == platform_pkg::PLIC_ENABLE) begin
                enable_q <= wdata_i[IRQ_COUNT:1];
            end
            mei_q <= |active;
            for (int i = 1; i <= IRQ_COUNT; i++) begin
                case (state_q[i])
                    platform_pkg::HS_IDLE: begin
                        if (irq_req_i[i-1]) state_q[i] <= platform_pkg::HS_REQ;  // now pending
                    end
                    platform_pkg::HS_REQ: begin
                        if (claim_rd && claim_id == 5'(i)) begin
                            state_q[i] <= platform_pkg::HS_ACK;
                        end
                    end
                    platform_pkg::HS_ACK: begin
                        if (!irq_req_i[i-1]) state_q[i] <= platform_pkg::HS_IDLE; // ack drops
                    end
                    default: state_q[i] <= platform_pkg::HS_IDLE;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////
    // register read
    ////////////////////////////////////////////////////

    always_comb begin
        rd_word = '0;
        case (addr_i)
            platform_pkg::PLIC_ENABLE:  rd_word[IRQ_COUNT:0] = {enable_q, 1'b0};
            platform_pkg::PLIC_PENDING: rd_word[IRQ_COUNT:0] = {pending, 1'b0};
            platform_pkg::PLIC_CLAIM:   rd_word[4:0]         = claim_id;
            default:                    rd_word              = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (en_i) rdata_q <= rd_word;
    end

    assign rdata_o = rdata_q;
    assign mei_o   = mei_q;

    for (genvar g = 0; g < IRQ_COUNT; g++) begin : g_ack_chk
        a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
            $rose(irq_ack_o[g]) |-> irq_req_i[g]);
    end

endmodule

// ==== source/rtc.sv ====
`timescale 1ns/1ns

module rtc #(
    parameter int TICK_DIV = 4
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            en_i,
    input  logic [3:0]                      we_i,
    input  logic [3:0]                      addr_i,
    input  logic [platform_pkg::DATA_W-1:0] wdata_i,
    output logic [platform_pkg::DATA_W-1:0] rdata_o,
    output logic                            mti_o
);

    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0]                div_q;
    logic                            tick;
    logic [63:0]                     mtime_q;
    logic [63:0]                     mtimecmp_q;
    logic                            mti_q;
    logic                            wr;
    logic                            mtime_wr;
    logic [platform_pkg::DATA_W-1:0] rd_word;
    logic [platform_pkg::DATA_W-1:0] rdata_q;

    assign wr       = en_i && (|we_i);          // whole-word writes only
    assign mtime_wr = wr && (addr_i == platform_pkg::RTC_MTIME_LO ||
                             addr_i == platform_pkg::RTC_MTIME_HI);
    assign tick     = (div_q == DIV_W'(TICK_DIV - 1));

    ////////////////////////////////////////////////////
    // prescaler and counters
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            div_q      <= '0;
            mtime_q    <= '0;
            mtimecmp_q <= '1;   // no timer irq until software sets it
            mti_q      <= 1'b0;
        end else begin
            div_q <= tick ? '0 : div_q + 1'b1;

            if (wr && addr_i == platform_pkg::RTC_MTIME_LO) begin
                mtime_q[31:0] <= wdata_i;
            end else if (wr && addr_i == platform_pkg::RTC_MTIME_HI) begin
                mtime_q[63:32] <= wdata_i;
            end else if (tick) begin
                mtime_q <= mtime_q + 64'd1;
            end

            if (wr && addr_i == platform_pkg::RTC_CMP_LO) mtimecmp_q[31:0]  <= wdata_i;
            if (wr && addr_i == platform_pkg::RTC_CMP_HI) mtimecmp_q[63:32] <= wdata_i;

            mti_q <= (mtime_q >= mtimecmp_q);   // seen one cycle after a cmp write
        end
    end

    always_comb begin
        case (addr_i)
            platform_pkg::RTC_MTIME_LO: rd_word = mtime_q[31:0];
            platform_pkg::RTC_MTIME_HI: rd_word = mtime_q[63:32];
            platform_pkg::RTC_CMP_LO:   rd_word = mtimecmp_q[31:0];
            platform_pkg::RTC_CMP_HI:   rd_word = mtimecmp_q[63:32];
            default:                    rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (en_i) rdata_q <= rd_word;
    end

    assign rdata_o = rdata_q;
    assign mti_o   = mti_q;

    a_mtime_mono: assert property (@(posedge clk) disable iff (!rst_n_i)
        !mtime_wr |=> (mtime_q >= $past(mtime_q)));

endmodule

// ==== source/soc_platform.sv ====
`timescale 1ns/1ns

module soc_platform #(
    parameter int IRQ_COUNT = 2,
    parameter int RAM_WORDS = 256,
    parameter int TICK_DIV  = 4
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  logic                            mem_en_i,
    input  logic [3:0]                      mem_we_i,
    input  logic [platform_pkg::ADDR_W-1:0] mem_addr_i,
    input  logic [platform_pkg::DATA_W-1:0] mem_wdata_i,
    output logic [platform_pkg::DATA_W-1:0] mem_rdata_o,
    input  logic [IRQ_COUNT-1:0]            btn_i,
    output logic [7:0]                      gpio_o,
    output logic                            mti_o,
    output logic                            mei_o
);

    localparam int RAM_AW = $clog2(RAM_WORDS);

    logic                            ram_en, rtc_en, plic_en, periph_en;
    logic [platform_pkg::DATA_W-1:0] ram_rdata, rtc_rdata, plic_rdata, periph_rdata;
    logic [IRQ_COUNT-1:0]            irq_req, irq_ack;

    ////////////////////////////////////////////////////
    // decoder
    ////////////////////////////////////////////////////

    bus_decoder i_bus_decoder (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .mem_en_i       (mem_en_i),
        .mem_addr_i     (mem_addr_i),
        .ram_en_o       (ram_en),
        .rtc_en_o       (rtc_en),
        .plic_en_o      (plic_en),
        .periph_en_o    (periph_en),
        .ram_rdata_i    (ram_rdata),
        .rtc_rdata_i    (rtc_rdata),
        .plic_rdata_i   (plic_rdata),
        .periph_rdata_i (periph_rdata),
        .mem_rdata_o    (mem_rdata_o)
    );

    ////////////////////////////////////////////////////
    // slaves
    ////////////////////////////////////////////////////

    data_ram #(.RAM_WORDS(RAM_WORDS)) i_data_ram (
        .clk     (clk),
        .en_i    (ram_en),
        .we_i    (mem_we_i),
        .addr_i  (mem_addr_i[RAM_AW+1:2]),     // word index
        .wdata_i (mem_wdata_i),
        .rdata_o (ram_rdata)
    );

    rtc #(.TICK_DIV(TICK_DIV)) i_rtc (
        .clk(clk), .rst_n_i(rst_n_i), .en_i(rtc_en), .we_i(mem_we_i),
        .addr_i(mem_addr_i[3:0]), .wdata_i(mem_wdata_i), .rdata_o(rtc_rdata), .mti_o(mti_o)
    );

    plic #(.IRQ_COUNT(IRQ_COUNT)) i_plic (
        .clk(clk), .rst_n_i(rst_n_i), .en_i(plic_en), .we_i(mem_we_i),
        .addr_i(mem_addr_i[3:0]), .wdata_i(mem_wdata_i), .rdata_o(plic_rdata),
        .irq_req_i(irq_req), .irq_ack_o(irq_ack), .mei_o(mei_o)
    );

    gpio_irq #(.IRQ_COUNT(IRQ_COUNT)) i_gpio_irq (
        .clk(clk), .rst_n_i(rst_n_i), .en_i(periph_en), .we_i(mem_we_i),
        .addr_i(mem_addr_i[3:0]), .wdata_i(mem_wdata_i), .rdata_o(periph_rdata),
        .btn_i(btn_i), .gpio_o(gpio_o), .irq_req_o(irq_req), .irq_ack_i(irq_ack)
    );

endmodule

// ==== src.f ====
source/platform_pkg.sv
source/bus_decoder.sv
source/data_ram.sv
source/rtc.sv
source/plic.sv
source/gpio_irq.sv
source/soc_platform.sv
testbench/tb_soc_platform.sv

// ==== testbench/tb_soc_platform.sv ====
`timescale 1ns/1ns

module tb_soc_platform;

    localparam int IRQ_COUNT  = 2;
    localparam int RAM_WORDS  = 256;
    localparam int TICK_DIV   = 4;
    localparam int CLK_PERIOD = 40;
    localparam int RAM_SPAN   = 32;                 // words used by the ram test
    localparam int RAM_WRITES = 40;
    localparam int GAP        = 20;                 // idle cycles between mtime reads
    localparam int MTI_WAIT   = 10 * TICK_DIV + 8;

    // watchdog allows twice the sum of these test lengths in cycles
    localparam int LEN_T1  = 2 * RAM_SPAN + RAM_WRITES + 4;
    localparam int LEN_T2  = 16;
    localparam int LEN_T3  = GAP + 10 + MTI_WAIT;
    localparam int LEN_T4  = 20;
    localparam int LEN_T5  = 50;
    localparam int LEN_T6  = 50;
    localparam int LEN_ALL = 5 + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5 + LEN_T6;

    logic                            clk;
    logic                            rst_n;
    logic                            mem_en;
    logic [3:0]                      mem_we;
    logic [platform_pkg::ADDR_W-1:0] mem_addr;
    logic [platform_pkg::DATA_W-1:0] mem_wdata;
    logic [platform_pkg::DATA_W-1:0] mem_rdata;
    logic [IRQ_COUNT-1:0]            btn;
    logic [7:0]                      gpio;
    logic                            mti;
    logic                            mei;

    // reference model state
    logic [31:0] ram_model [RAM_SPAN];
    logic [31:0] plic_en_model;
    logic [7:0]  gpio_model;
    logic [63:0] cmp_model;

    integer seed;
    int     errors;
    int     test_errors;
    int     failed_tests;

    soc_platform #(
        .IRQ_COUNT (IRQ_COUNT),
        .RAM_WORDS (RAM_WORDS),
        .TICK_DIV  (TICK_DIV)
    ) i_soc_platform (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .mem_en_i    (mem_en),
        .mem_we_i    (mem_we),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_rdata_o (mem_rdata),
        .btn_i       (btn),
        .gpio_o      (gpio),
        .mti_o       (mti),
        .mei_o       (mei)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // bus and helper tasks
    //////////////////////////////////////////////////

    // each task starts and ends 2 ns after an edge
    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        mem_en    = 1'b1;
        mem_we    = be;
        mem_addr  = addr;
        mem_wdata = data;
        @(posedge clk);
        #2;
        mem_en    = 1'b0;
        mem_we    = 4'h0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        mem_en   = 1'b1;
        mem_we   = 4'h0;
        mem_addr = addr;
        @(posedge clk);
        #2;
        mem_en   = 1'b0;
        data     = mem_rdata;      // word held during the cycle after the request
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic wait_mei(input logic level, input int max_cycles, output logic seen);
        int n;
        n = 0;
        while (mei !== level && n < max_cycles) begin
            @(posedge clk);
            #2;
            n++;
        end
        seen = (mei === level);
    endtask

    task automatic pulse_buttons(input logic [IRQ_COUNT-1:0] mask);
        btn = mask;
        idle(3);                   // long enough for the synchronizer
        btn = '0;
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - test_errors);
            failed_tests++;
        end
        test_errors = errors;
    endtask

    //////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////

    initial begin
        #(2 * LEN_ALL * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", 2 * LEN_ALL);
        $display("RESULT: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        logic [31:0] wd;
        logic [31:0] rd;
        logic [31:0] t0;
        logic [31:0] t1;
        logic [4:0]  idx;
        logic [3:0]  be;
        logic        seen;
        logic        low_held;
        int          n;

        seed         = 72;
        errors       = 0;
        test_errors  = 0;
        failed_tests = 0;
        clk          = 1'b0;
        rst_n        = 1'b0;
        mem_en       = 1'b0;
        mem_we       = 4'h0;
        mem_addr     = '0;
        mem_wdata    = '0;
        btn          = '0;
        cmp_model    = '1;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // ram with random byte enables (test 1)
        for (int i = 0; i < RAM_SPAN; i++) begin
            rnd          = $random(seed);
            ram_model[i] = rnd;
            bus_write(32'(i) << 2, 4'hF, rnd);
        end
        for (int k = 0; k < RAM_WRITES; k++) begin
            rnd = $random(seed);
            wd  = $random(seed);
            idx = rnd[4:0];
            be  = rnd[11:8];
            for (int b = 0; b < 4; b++) begin
                if (be[b]) ram_model[idx][b*8 +: 8] = wd[b*8 +: 8];
            end
            bus_write({25'h0, idx, 2'b00}, be, wd);
        end
        for (int i = 0; i < RAM_SPAN; i++) begin
            bus_read(32'(i) << 2, rd);
            check($sformatf("mem_rdata_o ram[%0d]", i), rd, ram_model[i]);
        end
        end_test("1 ram");

        // region routing (test 2)
        check("gpio_o after reset", 32'(gpio), 32'h0);
        check("mei_o after reset", 32'(mei), 32'h0);
        rnd        = $random(seed);
        gpio_model = rnd[7:0];
        bus_write({28'h8000000, platform_pkg::GPIO_OUT}, 4'hF, {24'h0, gpio_model});
        check("gpio_o", 32'(gpio), 32'(gpio_model));
        bus_read({28'h8000000, platform_pkg::GPIO_OUT}, rd);
        check("mem_rdata_o gpio_out", rd, 32'(gpio_model));
        bus_read({28'h8000000, platform_pkg::GPIO_IN}, rd);
        check("mem_rdata_o gpio_in", rd, 32'h0);
        plic_en_model = 32'h6;     // nothing pending yet
        bus_write({28'h3000000, platform_pkg::PLIC_ENABLE}, 4'hF, plic_en_model);
        bus_read({28'h3000000, platform_pkg::PLIC_ENABLE}, rd);
        check("mem_rdata_o plic enable", rd, plic_en_model);
        rnd              = $random(seed);
        cmp_model[63:32] = rnd;    // low word stays all ones
        bus_write({28'h2000000, platform_pkg::RTC_CMP_HI}, 4'hF, cmp_model[63:32]);
        bus_read({28'h2000000, platform_pkg::RTC_CMP_HI}, rd);
        check("mem_rdata_o cmp_hi", rd, cmp_model[63:32]);
        // ram words with the same low address bits as the writes above
        for (int k = 0; k < 4; k++) begin
            idx = 5'(k);
            bus_read({25'h0, idx, 2'b00}, rd);
            check($sformatf("mem_rdata_o ram[%0d]", idx), rd, ram_model[idx]);
        end
        bus_read({28'h3000000, 4'hC}, rd);
        check("mem_rdata_o plic unmapped", rd, 32'h0);
        bus_read({28'h8000000, 4'h8}, rd);
        check("mem_rdata_o gpio unmapped", rd, 32'h0);
        end_test("2 region routing");

        // rtc counter and compare (test 3)
        check("mti_o after reset", 32'(mti), 32'h0);
        bus_read({28'h2000000, platform_pkg::RTC_MTIME_LO}, t0);
        idle(GAP);
        bus_read({28'h2000000, platform_pkg::RTC_MTIME_LO}, t1);
        check("mtime_lo increase", 32'(t1 > t0), 32'h1);
        check("mtime_lo step bound", 32'((t1 - t0) <= 32'((GAP + 1) / TICK_DIV + 1)), 32'h1);
        bus_read({28'h2000000, platform_pkg::RTC_MTIME_HI}, rd);
        check("mem_rdata_o mtime_hi", rd, 32'h0);
        cmp_model = {32'h0, t1 + 32'd8};
        bus_write({28'h2000000, platform_pkg::RTC_CMP_HI}, 4'hF, cmp_model[63:32]);
        bus_write({28'h2000000, platform_pkg::RTC_CMP_LO}, 4'hF, cmp_model[31:0]);
        idle(1);
        check("mti_o before compare", 32'(mti), 32'h0);
        n = 0;
        while (mti !== 1'b1 && n < MTI_WAIT) begin
            idle(1);
            n++;
        end
        check("mti_o after compare", 32'(mti), 32'h1);
        bus_read({28'h2000000, platform_pkg::RTC_MTIME_LO}, rd);
        check("mtime_lo past compare", 32'(rd >= cmp_model[31:0]), 32'h1);
        end_test("3 rtc");

        // button to mei and claim (test 4)
        plic_en_model = 32'h2;         // source 1
        bus_write({28'h3000000, platform_pkg::PLIC_ENABLE}, 4'hF, plic_en_model);
        check("mei_o before pulse", 32'(mei), 32'h0);
        pulse_buttons(2'b01);
        wait_mei(1'b1, 7, seen);       // 10 cycles from the edge
        check("mei_o rise", 32'(seen), 32'h1);
        bus_read({28'h3000000, platform_pkg::PLIC_PENDING}, rd);
        check("mem_rdata_o pending", rd, 32'h2);
        bus_read({28'h3000000, platform_pkg::PLIC_CLAIM}, rd);
        check("mem_rdata_o claim", rd, 32'd1);
        wait_mei(1'b0, 2, seen);
        check("mei_o fall after claim", 32'(seen), 32'h1);
        idle(6);                       // handshake back to idle
        end_test("4 interrupt path");

        // priority, then mask (test 5)
        plic_en_model = 32'h6;
        bus_write({28'h3000000, platform_pkg::PLIC_ENABLE}, 4'hF, plic_en_model);
        pulse_buttons(2'b11);
        wait_mei(1'b1, 7, seen);
        check("mei_o rise", 32'(seen), 32'h1);
        bus_read({28'h3000000, platform_pkg::PLIC_CLAIM}, rd);
        check("mem_rdata_o first claim", rd, 32'd1);
        bus_read({28'h3000000, platform_pkg::PLIC_CLAIM}, rd);
        check("mem_rdata_o second claim", rd, 32'd2);
        wait_mei(1'b0, 2, seen);
        check("mei_o fall after claims", 32'(seen), 32'h1);
        idle(6);
        plic_en_model = 32'h2;         // source 2 masked
        bus_write({28'h3000000, platform_pkg::PLIC_ENABLE}, 4'hF, plic_en_model);
        pulse_buttons(2'b10);
        low_held = 1'b1;
        for (int k = 0; k < 10; k++) begin
            if (mei !== 1'b0) low_held = 1'b0;
            idle(1);
        end
        check("mei_o masked source", 32'(low_held), 32'h1);
        bus_read({28'h3000000, platform_pkg::PLIC_PENDING}, rd);
        check("mem_rdata_o pending masked", rd, 32'h4);
        end_test("5 priority and mask");

        // same button again after the claim (test 6)
        pulse_buttons(2'b01);
        wait_mei(1'b1, 7, seen);
        check("mei_o first pulse", 32'(seen), 32'h1);
        bus_read({28'h3000000, platform_pkg::PLIC_CLAIM}, rd);
        check("mem_rdata_o claim", rd, 32'd1);
        wait_mei(1'b0, 2, seen);
        check("mei_o fall after claim", 32'(seen), 32'h1);
        idle(6);
        pulse_buttons(2'b01);
        wait_mei(1'b1, 7, seen);
        check("mei_o second pulse", 32'(seen), 32'h1);
        bus_read({28'h3000000, platform_pkg::PLIC_CLAIM}, rd);
        check("mem_rdata_o claim again", rd, 32'd1);
        wait_mei(1'b0, 2, seen);
        check("mei_o fall again", 32'(seen), 32'h1);
        end_test("6 handshake completion");

        $display("tests run: 6, tests failed: %0d, check errors: %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
